/* alu_subsystem.f */
alu_pkg.sv
word_sram.sv
register_file.sv
alu_core.sv
program_loader.sv
integration_sequencer.sv
result_writeback.sv
alu_subsystem.sv
tb_alu_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build the ALU engine testbench with Verilator and run it.
# Fails when the build fails or the log holds the fail message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_alu_subsystem -f alu_subsystem.f -o sim_alu_subsystem &&
./obj_dir/sim_alu_subsystem | tee sim.log &&
! grep -q "Errors found" sim.log ||
{ echo "Simulation failed"; exit 1; }

/* tb_alu_subsystem.sv */
/*
   Testbench for the ALU integration engine.
   Loads data blocks and programs through the host port, predicts every result
   with a reference model and checks values and timing with concurrent
   assertions sampled mid-cycle. Six tests, one summary line each.
*/
`default_nettype none

module tb_alu_subsystem;
   timeunit 1ns;
   timeprecision 1ps;
   import alu_pkg::*;

   localparam int MAX_CYCLES = 3000; // Six tests of up to ~200 cycles, plus margin

   typedef struct packed {
      alu_result_t res;
      logic [31:0] cyc; // Cycle count when the strobe is seen
   } exp_item_t;

   logic clk, reset, load_valid, start, busy, result_valid, done;
   sram_addr_t load_addr;
   word_t load_data;
   logic [5:0] instr_count;
   alu_result_t result;

   logic [31:0] cycle = '0;      // Bumped on every rising edge
   word_t data_blk [DATA_BLOCK_WORDS];
   word_t prog [MAX_INSTR];
   int prog_len = 0;
   word_t model_regs [REG_COUNT];
   exp_item_t exp_arr [512];     // Expected results, all runs
   int exp_count = 0;            // Filled by stimulus
   int exp_idx = 0;              // Advanced as strobes retire
   logic [31:0] done_cycle = '0;
   int err_count = 0;
   int errs_before = 0;
   int tests_failed = 0;

   alu_subsystem dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (result_valid) begin
         exp_idx <= exp_idx + 1; // Checked at the previous falling edge
      end
   end

   task automatic report_error(string msg);
      $display("[ERROR] %0t %s", $time, msg);
      err_count++;
   endtask

   // Reference ALU, straight from the opcode rules
   function automatic alu_result_t ref_alu(logic [3:0] op, word_t a, word_t b, reg_addr_t d);
      alu_result_t r;
      logic [63:0] wide;
      longint exact; // Signed result at full precision
      r = '0;
      r.dest = d;
      exact = 0;
      case (op)
         4'd1: begin
            wide = {32'd0, a} + {32'd0, b};
            r.value = wide[31:0];
            r.flags.c = wide[32];
            exact = longint'($signed(a)) + longint'($signed(b));
         end
         4'd2: begin
            r.value = a - b;
            r.flags.c = (a >= b); // No borrow
            exact = longint'($signed(a)) - longint'($signed(b));
         end
         4'd3: r.value = a & b;
         4'd4: r.value = a | b;
         4'd5: r.value = a ^ b;
         4'd6: r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         4'd7: r.value = a << b[4:0];
         default: r.value = '0;
      endcase
      if (op == 4'd1 || op == 4'd2) begin
         r.flags.v = (exact != longint'($signed(r.value))); // Result does not fit
      end
      r.flags.z = (r.value == 32'd0);
      r.flags.n = r.value[31];
      return r;
   endfunction

   // Upper half gets junk, the engine must ignore it
   function automatic word_t make_instr(int op, int s0, int s1, int d);
      return {16'($urandom), 4'(op), 4'(s0), 4'(s1), 4'(d)};
   endfunction

   task automatic fill_data();
      for (int i = 0; i < DATA_BLOCK_WORDS; i++) begin
         data_blk[i] = $urandom;
      end
   endtask

   task automatic load_word(int addr, word_t w);
      @(negedge clk);
      load_valid = 1'b1;
      load_addr = sram_addr_t'(addr);
      load_data = w;
   endtask

   task automatic load_all();
      for (int i = 0; i < DATA_BLOCK_WORDS; i++) begin
         load_word(i, data_blk[i]);
      end
      for (int i = 0; i < prog_len; i++) begin
         load_word(PROG_BASE + i, prog[i]);
      end
      @(negedge clk);
      load_valid = 1'b0;
   endtask

   // Predict the run, pulse start, wait for done; poke adds host traffic mid-run
   task automatic run_program(bit poke);
      exp_item_t item;
      logic [3:0] op;
      @(negedge clk);
      for (int i = 0; i < REG_COUNT; i++) begin
         model_regs[i] = data_blk[i]; // Block copy
      end
      for (int k = 0; k < prog_len; k++) begin
         op = prog[k][15:12];
         if (op >= 4'd1 && op <= 4'd7) begin // NOP and 8..15 give nothing
            item.res = ref_alu(op, model_regs[prog[k][11:8]], model_regs[prog[k][7:4]],
                               prog[k][3:0]);
            item.cyc = cycle + 20 + 2 * k;
            model_regs[prog[k][3:0]] = item.res.value;
            exp_arr[exp_count] = item;
            exp_count++;
         end
      end
      done_cycle = cycle + 20 + 2 * (prog_len - 1);
      start = 1'b1;
      instr_count = 6'(prog_len);
      @(negedge clk);
      start = 1'b0;
      if (poke) begin
         repeat (20) @(negedge clk);
         load_valid = 1'b1;   // Would corrupt the first instruction
         load_addr = sram_addr_t'(PROG_BASE);
         load_data = ~prog[0];
         start = 1'b1;
         @(negedge clk);
         load_valid = 1'b0;
         start = 1'b0;
      end
      while (!done) begin
         @(negedge clk);
      end
      @(negedge clk); // Let the last strobe retire
   endtask

   task automatic end_test(string name);
      a_all_results: assert (exp_idx == exp_count)
         else report_error($sformatf("%0d results expected, %0d seen", exp_count, exp_idx));
      exp_count = exp_idx; // Resync for the next test
      if (err_count == errs_before) begin
         $display("%s: pass", name);
      end else begin
         $display("%s: fail, %0d errors", name, err_count - errs_before);
         tests_failed++;
      end
      errs_before = err_count;
   endtask

   initial begin
      int prev_dest;
      int next_dest;
      void'($urandom(32'h8ba3_d35c));
      reset = 1'b1;
      load_valid = 1'b0;
      load_addr = '0;
      load_data = '0;
      start = 1'b0;
      instr_count = 6'd1;
      repeat (10) @(negedge clk);
      reset = 1'b0;

      fill_data();
      for (int i = 0; i < 16; i++) begin
         prog[i] = make_instr(OR_OP, i, i, i); // Value is data word i
      end
      prog_len = 16;
      load_all();
      run_program(1'b0);
      end_test("test 1 block copy");

      fill_data();
      data_blk[0] = 32'h7fff_ffff;
      data_blk[1] = 32'h8000_0000;
      data_blk[2] = 32'hffff_ffff;
      data_blk[3] = 32'h0000_0000;
      data_blk[4] = 32'h0000_0001;
      prog[0] = make_instr(ADD, 0, 4, 10); // Overflow into negative
      prog[1] = make_instr(ADD, 2, 4, 11); // Carry out, zero
      prog[2] = make_instr(SUB, 3, 4, 12); // Borrow, negative
      prog[3] = make_instr(SUB, 1, 4, 13); // Overflow going down
      prog[4] = make_instr(SLT, 1, 0, 14);
      prog[5] = make_instr(SLL, 2, 2, 15); // Shift by 31
      for (int k = 6; k < 30; k++) begin
         prog[k] = make_instr(k % 8, $urandom, $urandom, $urandom);
      end
      prog_len = 30;
      load_all();
      run_program(1'b0);
      end_test("test 2 opcode coverage");

      fill_data();
      for (int k = 0; k < 9; k++) begin
         prog[2 * k] = make_instr((k == 0) ? 0 : 7 + k, $urandom, $urandom, k);
         prog[2 * k + 1] = make_instr(OR_OP, k, k, k); // Old value must survive
      end
      prog[18] = make_instr(15, 1, 2, 3); // Ends on a NOP
      prog_len = 19;
      load_all();
      run_program(1'b0);
      end_test("test 3 NOP behavior");

      fill_data();
      next_dest = $urandom % 16;
      for (int k = 0; k < 20; k++) begin
         prev_dest = next_dest;
         next_dest = $urandom % 16;
         prog[k] = make_instr(1 + $urandom % 7, prev_dest, $urandom, next_dest);
      end
      prog_len = 20;
      load_all();
      run_program(1'b0);
      end_test("test 4 dependency chain");

      prog[0] = make_instr(ADD, 1, 2, 3); // Shortest run
      prog_len = 1;
      load_all();
      run_program(1'b0);
      for (int k = 0; k < MAX_INSTR; k++) begin
         prog[k] = make_instr($urandom % 16, $urandom, $urandom, $urandom);
      end
      prog_len = MAX_INSTR; // Longest run
      load_all();
      run_program(1'b0);
      end_test("test 5 timing");

      fill_data();
      for (int k = 0; k < 16; k++) begin
         prog[k] = make_instr(1 + $urandom % 7, $urandom, $urandom, $urandom);
      end
      prog_len = 16;
      load_all();
      run_program(1'b1);
      run_program(1'b0); // Same SRAM contents, same results
      end_test("test 6 inputs while busy");

      $display("Tests run: 6, failed: %0d, errors: %0d", tests_failed, err_count);
      if (err_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // Watchdog
   initial begin
      wait (cycle >= MAX_CYCLES);
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
   end

   // Checks at the falling edge, where DUT outputs are settled
   a_reset_quiet: assert property (@(negedge clk)
      $past(reset) |-> !busy && !result_valid && !done)
      else report_error("busy, result_valid or done high after reset");

   a_result_expected: assert property (@(negedge clk) disable iff (reset)
      result_valid |-> exp_idx < exp_count)
      else report_error("result_valid with no result expected");

   a_result_value: assert property (@(negedge clk) disable iff (reset)
      (result_valid && exp_idx < exp_count) |-> result == exp_arr[exp_idx].res)
      else report_error($sformatf("result %h, expected %h", result, exp_arr[exp_idx].res));

   // First result 20 cycles after start, then 2 cycles per instruction
   a_result_cycle: assert property (@(negedge clk) disable iff (reset)
      (result_valid && exp_idx < exp_count) |-> cycle == exp_arr[exp_idx].cyc)
      else report_error($sformatf("result at cycle %0d, expected at %0d",
                                  cycle, exp_arr[exp_idx].cyc));

   a_done_cycle: assert property (@(negedge clk) disable iff (reset)
      done |-> cycle == done_cycle && !busy && $past(busy))
      else report_error($sformatf("done at cycle %0d, expected at %0d", cycle, done_cycle));

   a_busy_fall: assert property (@(negedge clk) disable iff (reset)
      $fell(busy) |-> done)
      else report_error("busy fell without done");

endmodule

`default_nettype wire

/* alu_subsystem.sv */
/*
   Top of the ALU integration engine.
   Host loads data and program into SRAM, pulses start, and collects one
   result per non-NOP instruction followed by a done pulse.
*/
`default_nettype none

module alu_subsystem (
   input  wire logic               clk,
   input  wire logic               reset,
   input  wire logic               load_valid,
   input  wire alu_pkg::sram_addr_t load_addr,
   input  wire alu_pkg::word_t     load_data,
   input  wire logic               start,
   input  wire logic [5:0]         instr_count,
   output logic                    busy,
   output logic                    result_valid,
   output alu_pkg::alu_result_t    result,
   output logic                    done
);
   import alu_pkg::*;

   // SRAM port
   logic sram_we;
   sram_addr_t sram_addr, rd_addr;
   word_t sram_wdata, sram_rdata;
   // Copy path and decode
   logic copy_we, issue, issue_last;
   reg_addr_t copy_addr, src0, src1, issue_dest;
   word_t copy_data;
   opcode_t opcode;
   // Register file and ALU
   logic fr_we;
   reg_addr_t fr_waddr;
   word_t fr_wdata, rdata0, rdata1, alu_value;
   alu_flags_t alu_flags;

   program_loader u_loader (
      .clk(clk), .reset(reset), .load_valid(load_valid), .load_addr(load_addr),
      .load_data(load_data), .busy(busy), .rd_addr(rd_addr),
      .sram_we(sram_we), .sram_addr(sram_addr), .sram_wdata(sram_wdata)
   );

   word_sram u_sram (
      .clk(clk), .we(sram_we), .addr(sram_addr), .wdata(sram_wdata), .rdata(sram_rdata)
   );

   integration_sequencer u_seq (
      .clk(clk), .reset(reset), .start(start), .instr_count(instr_count),
      .sram_rdata(sram_rdata), .busy(busy), .rd_addr(rd_addr),
      .copy_we(copy_we), .copy_addr(copy_addr), .copy_data(copy_data),
      .src0(src0), .src1(src1), .opcode(opcode), .issue(issue),
      .issue_dest(issue_dest), .issue_last(issue_last)
   );

   register_file u_fr (
      .clk(clk), .reset(reset), .we(fr_we), .waddr(fr_waddr), .wdata(fr_wdata),
      .raddr0(src0), .raddr1(src1), .rdata0(rdata0), .rdata1(rdata1)
   );

   alu_core u_alu (
      .operand0(rdata0), .operand1(rdata1), .opcode(opcode),
      .value(alu_value), .flags(alu_flags)
   );

   result_writeback u_wb (
      .clk(clk), .reset(reset), .issue(issue), .issue_dest(issue_dest),
      .issue_last(issue_last), .alu_value(alu_value), .alu_flags(alu_flags),
      .copy_we(copy_we), .copy_addr(copy_addr), .copy_data(copy_data),
      .fr_we(fr_we), .fr_waddr(fr_waddr), .fr_wdata(fr_wdata),
      .result_valid(result_valid), .result(result), .done(done)
   );

endmodule

`default_nettype wire

/* result_writeback.sv */
/*
   Writeback and result port.
   Captures the ALU value and flags at the end of the execute cycle, then
   writes the register file and presents result_valid in the next cycle.
   The same write port carries the block copy; done follows the last issue.
*/
`default_nettype none

module result_writeback (
   input  wire logic               clk,
   input  wire logic               reset,
   input  wire logic               issue,
   input  wire alu_pkg::reg_addr_t issue_dest,
   input  wire logic               issue_last,
   input  wire alu_pkg::word_t     alu_value,
   input  wire alu_pkg::alu_flags_t alu_flags,
   input  wire logic               copy_we,
   input  wire alu_pkg::reg_addr_t copy_addr,
   input  wire alu_pkg::word_t     copy_data,
   output logic                    fr_we,
   output alu_pkg::reg_addr_t      fr_waddr,
   output alu_pkg::word_t          fr_wdata,
   output logic                    result_valid,
   output alu_pkg::alu_result_t    result,
   output logic                    done
);
   import alu_pkg::*;

   always_ff @(posedge clk) begin
      if (reset) begin
         result_valid <= 1'b0;
         done <= 1'b0;
      end else begin
         result_valid <= issue;
         done <= issue_last; // Lines up with busy falling
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         result <= '{dest: issue_dest, value: alu_value, flags: alu_flags};
      end
   end

   // Copy and pending result share the FR port
   assign fr_we    = copy_we || result_valid;
   assign fr_waddr = result_valid ? result.dest : copy_addr;
   assign fr_wdata = result_valid ? result.value : copy_data;

   // Copy phase ends before the first issue, so they never overlap
   a_port_conflict: assert property (
      @(posedge clk) disable iff (reset) copy_we |-> !result_valid
   ) else $error("[ERROR] %0t copy write collides with result write", $time);

endmodule

`default_nettype wire

/* integration_sequencer.sv */
/*
   Run control for the ALU engine.
   On start it copies the data block from SRAM into the register file, then
   loops fetch and execute over the program. In the execute cycle the SRAM
   word is decoded and the operands, opcode and issue strobe go out.
*/
`default_nettype none

module integration_sequencer (
   input  wire logic               clk,
   input  wire logic               reset,
   input  wire logic               start,
   input  wire logic [5:0]         instr_count,
   input  wire alu_pkg::word_t     sram_rdata,
   output logic                    busy,
   output alu_pkg::sram_addr_t     rd_addr,
   output logic                    copy_we,
   output alu_pkg::reg_addr_t      copy_addr,
   output alu_pkg::word_t          copy_data,
   output alu_pkg::reg_addr_t      src0,
   output alu_pkg::reg_addr_t      src1,
   output alu_pkg::opcode_t        opcode,
   output logic                    issue,
   output alu_pkg::reg_addr_t      issue_dest,
   output logic                    issue_last
);
   import alu_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      COPY,
      FETCH,
      EXEC
   } state_t;

   state_t state;
   logic [4:0] copy_cnt; // 0..16, 17 copy cycles
   logic [5:0] pc;       // Instruction index
   logic [5:0] last_pc;  // instr_count - 1, held for the run
   alu_instr_t instr;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
         copy_cnt <= '0;
         pc <= '0;
         last_pc <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin // Start while busy cannot land here
                  state <= COPY;
                  copy_cnt <= '0;
                  pc <= '0;
                  last_pc <= instr_count - 6'd1;
               end
            end
            COPY: begin
               if (copy_cnt == 5'(DATA_BLOCK_WORDS)) begin
                  state <= FETCH; // Last write lands this cycle
               end else begin
                  copy_cnt <= copy_cnt + 5'd1;
               end
            end
            FETCH: state <= EXEC; // SRAM read in flight
            EXEC: begin
               if (pc == last_pc) begin
                  state <= IDLE;
               end else begin
                  pc <= pc + 6'd1;
                  state <= FETCH;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign busy = (state != IDLE);

   // Copy reads run one ahead of copy writes
   always_comb begin
      if (state == COPY) begin
         rd_addr = sram_addr_t'(copy_cnt);
      end else begin
         rd_addr = sram_addr_t'(PROG_BASE) + pc; // Program fetch
      end
   end

   assign copy_we   = (state == COPY) && (copy_cnt != '0);
   assign copy_addr = reg_addr_t'(copy_cnt - 5'd1); // Write trails read by one
   assign copy_data = sram_rdata;

   // Decode, valid in EXEC only
   assign instr      = alu_instr_t'(sram_rdata);
   assign src0       = instr.src0;
   assign src1       = instr.src1;
   assign opcode     = instr.opcode;
   assign issue_dest = instr.dest;
   // NOP and codes 8..15 never issue
   assign issue      = (state == EXEC) &&
                       (instr.opcode inside {ADD, SUB, AND_OP, OR_OP, XOR_OP, SLT, SLL});
   assign issue_last = (state == EXEC) && (pc == last_pc); // Even on a NOP

   // Host must give a program length that fits in the SRAM
   a_count_range: assert property (
      @(posedge clk) disable iff (reset)
      (start && !busy) |-> (instr_count >= 6'd1 && instr_count <= 6'(MAX_INSTR))
   ) else $error("[ERROR] %0t instr_count %0d out of range", $time, instr_count);

endmodule

`default_nettype wire

/* program_loader.sv */
/*
   Host side of the SRAM port.
   Registers each host load word and writes it one cycle later while the
   engine is idle. During a run the port follows the sequencer read address
   and host loads are dropped.
*/
`default_nettype none

module program_loader (
   input  wire logic               clk,
   input  wire logic               reset,
   input  wire logic               load_valid,
   input  wire alu_pkg::sram_addr_t load_addr,
   input  wire alu_pkg::word_t     load_data,
   input  wire logic               busy,
   input  wire alu_pkg::sram_addr_t rd_addr,
   output logic                    sram_we,
   output alu_pkg::sram_addr_t     sram_addr,
   output alu_pkg::word_t          sram_wdata
);
   import alu_pkg::*;

   logic pend_valid;      // Host word waiting for the port
   sram_addr_t pend_addr;
   word_t pend_data;

   always_ff @(posedge clk) begin
      if (reset) begin
         pend_valid <= 1'b0;
      end else begin
         pend_valid <= load_valid && !busy; // Loads during a run are lost
      end
   end

   always_ff @(posedge clk) begin
      if (load_valid) begin
         pend_addr <= load_addr;
         pend_data <= load_data;
      end
   end

   // Port mux, sequencer owns it while busy
   assign sram_we    = pend_valid && !busy;
   assign sram_addr  = busy ? rd_addr : pend_addr;
   assign sram_wdata = pend_data;

   // A host load seen during a run never reaches the array
   a_no_load_when_busy: assert property (
      @(posedge clk) disable iff (reset) (load_valid && busy) |=> !sram_we
   ) else $error("[ERROR] %0t host load written during a run", $time);

endmodule

`default_nettype wire

/* alu_core.sv */
/*
   Combinational ALU, eight opcodes.
   Produces the result word and Z, V, C, N flags. Carry and overflow only
   come from ADD and SUB; zero and negative always track the result.
*/
`default_nettype none

module alu_core (
   input  wire alu_pkg::word_t   operand0,
   input  wire alu_pkg::word_t   operand1,
   input  wire alu_pkg::opcode_t opcode,
   output alu_pkg::word_t        value,
   output alu_pkg::alu_flags_t   flags
);
   import alu_pkg::*;

   logic [WORD_W:0] sum; // Extra bit holds the carry

   always_comb begin
      sum = '0;
      value = '0;
      flags = '0;
      case (opcode)
         ADD: begin
            sum = {1'b0, operand0} + {1'b0, operand1};
            value = sum[WORD_W-1:0];
            flags.c = sum[WORD_W];
            // Same signs in, different sign out
            flags.v = (operand0[WORD_W-1] == operand1[WORD_W-1]) &&
                      (value[WORD_W-1] != operand0[WORD_W-1]);
         end
         SUB: begin
            // a + ~b + 1, c set when a >= b unsigned
            sum = {1'b0, operand0} + {1'b0, ~operand1} + 1'b1;
            value = sum[WORD_W-1:0];
            flags.c = sum[WORD_W];
            flags.v = (operand0[WORD_W-1] != operand1[WORD_W-1]) &&
                      (value[WORD_W-1] != operand0[WORD_W-1]);
         end
         AND_OP: value = operand0 & operand1;
         OR_OP:  value = operand0 | operand1;
         XOR_OP: value = operand0 ^ operand1;
         SLT:    value = word_t'($signed(operand0) < $signed(operand1)); // Signed compare
         SLL:    value = operand0 << operand1[4:0]; // Low 5 bits only
         default: value = '0; // NOP and codes 8..15
      endcase
      flags.z = (value == '0);
      flags.n = value[WORD_W-1];
   end

endmodule

`default_nettype wire

/* register_file.sv */
/*
   16 x 32 register file for the ALU engine.
   Two combinational read ports feed the ALU, one synchronous write port is
   shared by block copy and writeback. Reset clears every register.
*/
`default_nettype none

module register_file (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              we,
   input  wire alu_pkg::reg_addr_t waddr,
   input  wire alu_pkg::word_t    wdata,
   input  wire alu_pkg::reg_addr_t raddr0,
   input  wire alu_pkg::reg_addr_t raddr1,
   output alu_pkg::word_t         rdata0,
   output alu_pkg::word_t         rdata1
);
   import alu_pkg::*;

   word_t regs [REG_COUNT];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[waddr] <= wdata;
      end
   end

   // Operands for the execute cycle
   assign rdata0 = regs[raddr0];
   assign rdata1 = regs[raddr1];

endmodule

`default_nettype wire

/* word_sram.sv */
/*
   Single-port synchronous SRAM, 64 words.
   Holds the data block and the ALU program. Read data is registered and
   appears one cycle after the address. Write and read share the port.
*/
`default_nettype none

module word_sram (
   input  wire logic              clk,
   input  wire logic              we,
   input  wire alu_pkg::sram_addr_t addr,
   input  wire alu_pkg::word_t    wdata,
   output alu_pkg::word_t         rdata
);
   import alu_pkg::*;

   word_t mem [SRAM_DEPTH]; // No reset, contents come from the host

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr]; // Old data on a write cycle
   end

endmodule

`default_nettype wire

/* alu_pkg.sv */
/*
   Shared definitions for the ALU integration engine.
   Widths, the opcode set, the instruction word layout and the result record.
   Modules import it inside their bodies and use scoped names on their ports.
*/
`default_nettype none

package alu_pkg;

   // Widths and sizes
   localparam int WORD_W = 32;
   localparam int REG_ADDR_W = 4;
   localparam int SRAM_ADDR_W = 6;
   localparam int SRAM_DEPTH = 64;       // Data block plus program
   localparam int REG_COUNT = 16;

   // Memory map
   localparam int DATA_BLOCK_WORDS = 16; // SRAM 0..15 copied to regs 0..15
   localparam int PROG_BASE = 16;        // First instruction word
   localparam int MAX_INSTR = 48;        // Rest of the SRAM

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

   // Codes 8..15 are undefined and behave as NOP
   typedef enum logic [3:0] {
      NOP    = 4'd0,
      ADD    = 4'd1,
      SUB    = 4'd2,
      AND_OP = 4'd3,
      OR_OP  = 4'd4,
      XOR_OP = 4'd5,
      SLT    = 4'd6,
      SLL    = 4'd7
   } opcode_t;

   typedef struct packed {
      logic z; // Zero
      logic v; // Signed overflow
      logic c; // Carry out of bit 31
      logic n; // Negative
   } alu_flags_t;

   // One instruction per SRAM word, upper half unused
   typedef struct packed {
      logic [15:0] unused;
      opcode_t opcode;
      reg_addr_t src0;
      reg_addr_t src1;
      reg_addr_t dest;
   } alu_instr_t;

   // What the host sees for each executed instruction
   typedef struct packed {
      reg_addr_t dest;
      word_t value;
      alu_flags_t flags;
   } alu_result_t;

endpackage

`default_nettype wire
